/* compile.f */
+incdir+dv
common/ecd_axi_pkg.sv
common/ecd_ctrl_pkg.sv
regs/ecd_regs.sv
fetch/ecd_burst_issuer.sv
fetch/ecd_stream_out.sv
hdl/ecd_master_ctrl.sv
dv/tb_ecd_master_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DMA testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module tb_ecd_master_ctrl -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0

/* dv/ecd_tb_model.svh */
`ifndef ECD_TB_MODEL_SVH
`define ECD_TB_MODEL_SVH

// ========================================
// Reference model for the DMA testbench
// ========================================

// Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

// Address of the n-th accepted burst wraps back to base every size blocks
function automatic ecd_axi_pkg::axi_addr_t expected_addr(
    input ecd_axi_pkg::axi_addr_t base,
    input int unsigned            n,
    input int unsigned            size,
    input int unsigned            stride
);
    return base + ecd_axi_pkg::axi_addr_t'((n % size) * stride);
endfunction

// Stream byte 0 is the last byte on the bus
function automatic ecd_axi_pkg::axi_data_t reverse_bytes(input ecd_axi_pkg::axi_data_t d);
    ecd_axi_pkg::axi_data_t r;
    for (int i = 0; i < 64; i++) begin
        r[8*i +: 8] = d[8*(63-i) +: 8];
    end
    return r;
endfunction

`endif

/* dv/tb_ecd_master_ctrl.sv */
`timescale 1ns/1ps

module tb_ecd_master_ctrl;

    import ecd_axi_pkg::*;

    `include "ecd_tb_model.svh"

    localparam int beats     = 4;
    localparam int stride    = 64 * beats;
    localparam int buf_size  = 3;
    localparam int run_burst = 12;
    // Worst case cycles for one burst under random stalls
    localparam int burst_cyc = 200;
    localparam int setup_cyc = 1000;

    // AXI response encodings
    localparam axi_resp_t okay_rsp   = 2'b00;
    localparam axi_resp_t decerr_rsp = 2'b11;

    logic       clk = 1'b0;
    logic       resetn;
    axil_wreq_t s_wreq;
    logic       s_aw_ready;
    logic       s_w_ready;
    axil_wrsp_t s_wrsp;
    logic       s_b_ready;
    axil_rreq_t s_rreq;
    logic       s_ar_ready;
    axil_rrsp_t s_rrsp;
    logic       s_r_ready;
    axi_ar_t    m_ar;
    logic       m_ar_ready = 1'b0;
    axi_r_t     m_r = '0;
    logic       m_r_ready;
    axis_t      tx;
    logic       tx_ready = 1'b0;
    logic       irq_eob;
    logic       draining;

    // Stimulus state
    logic [15:0] lfsr_state = 16'd40;
    int          phase = 0;
    int unsigned errors = 0;
    int unsigned drain_sent = 0;
    int unsigned drained = 0;
    int unsigned ar_count = 0;
    int unsigned beats_sent = 0;
    int unsigned tx_count = 0;
    int unsigned last_count = 0;
    int unsigned irq_count = 0;
    logic        r_fired = 1'b0;
    logic        irq_due = 1'b0;
    axi_addr_t   base_addr;
    axi_data_t   exp_q[$];
    axil_data_t  hi_val;
    axil_data_t  lo_val;

    ecd_master_ctrl #(.beats_per_burst(beats)) i_dut (
        .clk(clk), .resetn(resetn),
        .s_wreq(s_wreq), .s_aw_ready(s_aw_ready), .s_w_ready(s_w_ready),
        .s_wrsp(s_wrsp), .s_b_ready(s_b_ready),
        .s_rreq(s_rreq), .s_ar_ready(s_ar_ready), .s_rrsp(s_rrsp), .s_r_ready(s_r_ready),
        .m_ar(m_ar), .m_ar_ready(m_ar_ready), .m_r(m_r), .m_r_ready(m_r_ready),
        .tx(tx), .tx_ready(tx_ready), .irq_eob(irq_eob), .draining(draining)
    );

    always #5 clk = ~clk;

    function automatic logic rand_bit();
        lfsr_state = lfsr_next(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic axi_data_t rand_beat();
        axi_data_t d;
        for (int i = 0; i < axi_data_w; i++) begin
            d[i] = rand_bit();
        end
        return d;
    endfunction

    // ========================================
    // Register port tasks
    // ========================================
    task automatic axil_write(input axil_addr_t a, input axil_data_t d,
                              input axi_resp_t exp, input string name);
        int waited;
        waited = 0;
        @(posedge clk);
        s_wreq <= '{aw_addr: a, aw_valid: 1'b1, w_data: d, w_valid: 1'b1};
        @(negedge clk);
        while (!s_aw_ready && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!s_aw_ready) begin
            $display("%s: write was never accepted", name);
            errors++;
        end else if (!s_w_ready) begin
            $display("[ERROR] %s w_ready expected 1 actual 0", name);
            errors++;
        end
        @(posedge clk);
        s_wreq    <= '0;
        s_b_ready <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!s_wrsp.valid && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!s_wrsp.valid) begin
            $display("%s: no write response arrived", name);
            errors++;
        end else if (s_wrsp.resp != exp) begin
            $display("[ERROR] %s expected %0h actual %0h", name, exp, s_wrsp.resp);
            errors++;
        end
        @(posedge clk);
        s_b_ready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t a, input axil_data_t exp_d,
                             input axi_resp_t exp, input string name);
        int waited;
        waited = 0;
        @(posedge clk);
        s_rreq <= '{addr: a, valid: 1'b1};
        @(negedge clk);
        while (!s_ar_ready && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        s_rreq    <= '0;
        s_r_ready <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!s_rrsp.valid && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (!s_rrsp.valid) begin
            $display("%s: no read response arrived", name);
            errors++;
        end else if (s_rrsp.resp != exp) begin
            $display("[ERROR] %s expected %0h actual %0h", name, exp, s_rrsp.resp);
            errors++;
        end else if (exp == okay_rsp && s_rrsp.data != exp_d) begin
            $display("[ERROR] %s expected %h actual %h", name, exp_d, s_rrsp.data);
            errors++;
        end
        @(posedge clk);
        s_r_ready <= 1'b0;
    endtask

    // ========================================
    // Read slave and stream sink drive
    // ========================================
    always @(posedge clk) begin
        if (phase == 1) begin
            // Stray beats while idle
            if (drain_sent < 4) begin
                m_r <= '{data: rand_beat(), last: 1'b0, valid: 1'b1};
                drain_sent <= drain_sent + 1;
            end else begin
                m_r.valid <= 1'b0;
            end
        end else if (phase == 2) begin
            m_ar_ready <= rand_bit();
            tx_ready   <= rand_bit();
            if (!m_r.valid || r_fired) begin
                // Next beat only for bursts already requested and with random gaps
                if (beats_sent / beats < ar_count && beats_sent < run_burst * beats
                    && rand_bit()) begin
                    m_r.data  <= rand_beat();
                    m_r.last  <= (beats_sent % beats == beats - 1);
                    m_r.valid <= 1'b1;
                    beats_sent <= beats_sent + 1;
                end else begin
                    m_r.valid <= 1'b0;
                end
            end
        end
    end

    // ========================================
    // Monitors sampled mid-cycle
    // ========================================
    always @(negedge clk) begin
        r_fired = m_r.valid && m_r_ready;
        if (phase != 2) begin
            if (m_r.valid) begin
                if (tx.valid || !draining || !m_r_ready) begin
                    $display("Idle beat was not dropped with draining set");
                    errors++;
                end
                drained++;
            end else if (draining) begin
                $display("Draining was set with no read beat present");
                errors++;
            end
        end
        if (phase == 2) begin
            if (m_ar.valid && m_ar_ready) begin
                if (m_ar.addr != expected_addr(base_addr, ar_count, buf_size, stride)) begin
                    $display("[ERROR] ar_addr expected %h actual %h",
                             expected_addr(base_addr, ar_count, buf_size, stride), m_ar.addr);
                    errors++;
                end
                if (m_ar.len != 8'd3 || m_ar.size != 3'd6 || m_ar.burst != 2'b01) begin
                    $display("[ERROR] ar_shape expected 3/6/1 actual %0d/%0d/%0d",
                             m_ar.len, m_ar.size, m_ar.burst);
                    errors++;
                end
                ar_count++;
            end
            if (tx.valid != m_r.valid) begin
                $display("[ERROR] tx_valid expected %b actual %b", m_r.valid, tx.valid);
                errors++;
            end
            if (draining) begin
                $display("[ERROR] draining expected 0 actual 1");
                errors++;
            end
            if (r_fired) begin
                exp_q.push_back(reverse_bytes(m_r.data));
                if (m_r.last) begin
                    last_count++;
                end
            end
            if (tx.valid && tx_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Stream beat arrived with no read beat behind it");
                    errors++;
                end else if (tx.data != exp_q[0]) begin
                    $display("[ERROR] tx_data expected %h actual %h", exp_q[0], tx.data);
                    errors++;
                    void'(exp_q.pop_front());
                end else begin
                    void'(exp_q.pop_front());
                end
                tx_count++;
            end
        end
        // Interrupt comes one cycle after the closing beat of every third burst
        if (irq_eob != irq_due) begin
            $display("[ERROR] irq_eob expected %b actual %b", irq_due, irq_eob);
            errors++;
        end
        if (irq_eob) begin
            irq_count++;
        end
        irq_due = (phase == 2) && r_fired && m_r.last && (last_count % buf_size == 0);
    end

    // Hang guard sized from the burst count of the run
    initial begin
        #((setup_cyc + run_burst * burst_cyc) * 10);
        $display("Watchdog expired before all bursts were streamed");
        $display("** FAIL **");
        $finish;
    end

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        resetn    = 1'b0;
        s_wreq    = '0;
        s_b_ready = 1'b0;
        s_rreq    = '0;
        s_r_ready = 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;

        // Reset values, read-back and decode errors
        axil_read(32'h0, 32'h0000_0000, okay_rsp, "reset_buffh");
        axil_read(32'h4, 32'hC000_0000, okay_rsp, "reset_buffl");
        axil_read(32'h8, 32'd8, okay_rsp, "reset_size");
        for (int i = 0; i < 32; i++) begin
            hi_val[i] = rand_bit();
            lo_val[i] = rand_bit();
        end
        axil_write(32'h0, hi_val, okay_rsp, "write_buffh");
        axil_write(32'h4, lo_val, okay_rsp, "write_buffl");
        axil_write(32'h8, buf_size, okay_rsp, "write_size");
        axil_read(32'h0, hi_val, okay_rsp, "readback_buffh");
        axil_read(32'h4, lo_val, okay_rsp, "readback_buffl");
        axil_read(32'h8, buf_size, okay_rsp, "readback_size");
        axil_write(32'h14, 32'h1234, decerr_rsp, "write_idx5");
        axil_read(32'h14, 32'h0, decerr_rsp, "read_idx5");
        axil_read(32'hC, 32'h0, decerr_rsp, "read_start");
        base_addr = {hi_val, lo_val};

        // Beats before start are drained
        @(posedge clk);
        phase <= 1;
        wait (drain_sent == 4);
        @(posedge clk);
        @(posedge clk);
        phase <= 2;
        axil_write(32'hC, 32'h1, okay_rsp, "write_start");

        wait (tx_count == run_burst * beats);
        repeat (10) @(posedge clk);
        if (drained != 4) begin
            $display("[ERROR] drained expected 4 actual %0d", drained);
            errors++;
        end
        if (exp_q.size() != 0) begin
            $display("Read beats were accepted but never streamed");
            errors++;
        end
        if (irq_count != run_burst / buf_size) begin
            $display("[ERROR] irq_count expected %0d actual %0d", run_burst / buf_size,
                     irq_count);
            errors++;
        end
        $display("Checks done: %0d errors, %0d bursts, %0d beats, %0d interrupts",
                 errors, last_count, tx_count, irq_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* hdl/ecd_master_ctrl.sv */
`timescale 1ns/1ps

module ecd_master_ctrl #(
    parameter int beats_per_burst = 32
) (
    input  logic                    clk,
    input  logic                    resetn,

    // ========================================
    // AXI4-Lite register port
    // ========================================
    input  ecd_axi_pkg::axil_wreq_t s_wreq,
    output logic                    s_aw_ready,
    output logic                    s_w_ready,
    output ecd_axi_pkg::axil_wrsp_t s_wrsp,
    input  logic                    s_b_ready,
    input  ecd_axi_pkg::axil_rreq_t s_rreq,
    output logic                    s_ar_ready,
    output ecd_axi_pkg::axil_rrsp_t s_rrsp,
    input  logic                    s_r_ready,

    // ========================================
    // AXI4 read master
    // ========================================
    output ecd_axi_pkg::axi_ar_t    m_ar,
    input  logic                    m_ar_ready,
    input  ecd_axi_pkg::axi_r_t     m_r,
    output logic                    m_r_ready,

    // ========================================
    // Stream out and status
    // ========================================
    output ecd_axi_pkg::axis_t      tx,
    input  logic                    tx_ready,
    output logic                    irq_eob,
    output logic                    draining
);

    import ecd_ctrl_pkg::*;

    // Buffer setup from software
    buf_cfg_t cfg;
    logic     start;
    // Issuer is active
    logic     fetching;

    // Register file and host interface
    ecd_regs i_regs (
        .clk        (clk),
        .resetn     (resetn),
        .s_wreq     (s_wreq),
        .s_aw_ready (s_aw_ready),
        .s_w_ready  (s_w_ready),
        .s_wrsp     (s_wrsp),
        .s_b_ready  (s_b_ready),
        .s_rreq     (s_rreq),
        .s_ar_ready (s_ar_ready),
        .s_rrsp     (s_rrsp),
        .s_r_ready  (s_r_ready),
        .cfg        (cfg),
        .start      (start)
    );

    // AR request generation
    ecd_burst_issuer #(
        .beats_per_burst (beats_per_burst)
    ) i_issuer (
        .clk        (clk),
        .resetn     (resetn),
        .cfg        (cfg),
        .start      (start),
        .m_ar       (m_ar),
        .m_ar_ready (m_ar_ready),
        .fetching   (fetching)
    );

    // Read data to stream plus interrupt
    ecd_stream_out i_stream (
        .clk       (clk),
        .resetn    (resetn),
        .cfg       (cfg),
        .start     (start),
        .fetching  (fetching),
        .m_r       (m_r),
        .m_r_ready (m_r_ready),
        .tx        (tx),
        .tx_ready  (tx_ready),
        .irq_eob   (irq_eob),
        .draining  (draining)
    );

endmodule

/* fetch/ecd_stream_out.sv */
`timescale 1ns/1ps

module ecd_stream_out (
    input  logic                   clk,
    input  logic                   resetn,
    input  ecd_ctrl_pkg::buf_cfg_t cfg,
    input  logic                   start,
    input  logic                   fetching,
    input  ecd_axi_pkg::axi_r_t    m_r,
    output logic                   m_r_ready,
    output ecd_axi_pkg::axis_t     tx,
    input  logic                   tx_ready,
    output logic                   irq_eob,
    draining
);

    import ecd_axi_pkg::*;
    import ecd_ctrl_pkg::*;

    axi_data_t  swapped;
    logic       r_fire;
    blk_count_t blocks_left;

    // ========================================
    // Data path
    // ========================================

    // Bus delivers little-endian so flip the 64 bytes back
    always_comb begin
        for (int i = 0; i < axi_data_bytes; i++) begin
            swapped[i*8 +: 8] = m_r.data[(axi_data_bytes-1-i)*8 +: 8];
        end
    end

    // Stream only sees beats while a transfer is running
    assign tx = '{data: swapped, valid: m_r.valid && fetching};

    // When idle everything is taken and dropped
    assign m_r_ready = tx_ready || !fetching;
    assign r_fire    = m_r.valid && m_r_ready;
    assign draining  = r_fire && !fetching;

    // ========================================
    // End-of-buffer tracking
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            blocks_left <= '0;
            irq_eob     <= 1'b0;
        end else begin
            irq_eob <= 1'b0;
            if (start) begin
                blocks_left <= cfg.size;
            end else if (fetching && r_fire && m_r.last) begin
                // One block finished
                if (blocks_left == blk_count_t'(1)) begin
                    blocks_left <= cfg.size;
                    irq_eob     <= 1'b1;
                end else begin
                    blocks_left <= blocks_left - blk_count_t'(1);
                end
            end
        end
    end

    // Interrupt is a single-cycle strobe
    a_irq_pulse: assert property (@(posedge clk) disable iff (!resetn)
        irq_eob |=> !irq_eob);

endmodule

/* fetch/ecd_burst_issuer.sv */
`timescale 1ns/1ps

module ecd_burst_issuer #(
    parameter int beats_per_burst = 32
) (
    input  logic                   clk,
    input  logic                   resetn,
    input  ecd_ctrl_pkg::buf_cfg_t cfg,
    input  logic                   start,
    output ecd_axi_pkg::axi_ar_t   m_ar,
    input  logic                   m_ar_ready,
    output logic                   fetching
);

    import ecd_axi_pkg::*;
    import ecd_ctrl_pkg::*;

    // Address step from one burst to the next
    localparam axi_addr_t burst_stride = axi_addr_t'(axi_data_bytes * beats_per_burst);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_issue
    } issue_state_t;

    issue_state_t state;
    axi_addr_t    ar_addr;
    blk_count_t   blocks_left;
    logic         ar_valid;
    logic         ar_fire;
    logic         last_block;

    assign ar_fire    = ar_valid && m_ar_ready;
    assign last_block = (blocks_left == blk_count_t'(1));

    // ========================================
    // Request sequencer
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= st_idle;
            ar_valid    <= 1'b0;
            blocks_left <= '0;
        end else begin
            case (state)
                // Wait for software to kick us off
                st_idle: begin
                    if (start) begin
                        state <= st_load;
                    end
                end
                // Take a fresh copy of the buffer size
                st_load: begin
                    blocks_left <= cfg.size;
                    ar_valid    <= 1'b1;
                    state       <= st_issue;
                end
                st_issue: begin
                    if (ar_fire) begin
                        if (last_block) begin
                            // Buffer covered so go round again
                            ar_valid <= 1'b0;
                            state    <= st_load;
                        end else begin
                            blocks_left <= blocks_left - blk_count_t'(1);
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Running burst address
    always_ff @(posedge clk) begin
        if (state == st_load) begin
            ar_addr <= cfg.base;
        end else if (state == st_issue && ar_fire && !last_block) begin
            ar_addr <= ar_addr + burst_stride;
        end
    end

    // Burst shape is fixed by the parameter and the bus width
    assign m_ar = '{
        addr:  ar_addr,
        len:   axi_len_t'(beats_per_burst - 1),
        size:  axi_size_t'($clog2(axi_data_bytes)),
        burst: burst_incr,
        valid: ar_valid
    };

    assign fetching = (state != st_idle);

    // Request must not change while the slave stalls it
    a_ar_stable: assert property (@(posedge clk) disable iff (!resetn)
        m_ar.valid && !m_ar_ready |=> m_ar.valid && $stable(m_ar.addr));

    // Consecutive bursts of one buffer are one stride apart
    a_ar_stride: assert property (@(posedge clk) disable iff (!resetn)
        ar_fire && !last_block |=> m_ar.addr == $past(m_ar.addr) + burst_stride);

endmodule

/* regs/ecd_regs.sv */
`timescale 1ns/1ps

module ecd_regs (
    input  logic                    clk,
    input  logic                    resetn,

    // AXI4-Lite write side
    input  ecd_axi_pkg::axil_wreq_t s_wreq,
    output logic                    s_aw_ready,
    output logic                    s_w_ready,
    output ecd_axi_pkg::axil_wrsp_t s_wrsp,
    input  logic                    s_b_ready,

    // AXI4-Lite read side
    input  ecd_axi_pkg::axil_rreq_t s_rreq,
    output logic                    s_ar_ready,
    output ecd_axi_pkg::axil_rrsp_t s_rrsp,
    input  logic                    s_r_ready,

    // Buffer setup and start strobe
    output ecd_ctrl_pkg::buf_cfg_t  cfg,
    output logic                    start
);

    import ecd_axi_pkg::*;
    import ecd_ctrl_pkg::*;

    // Register file
    axil_data_t buffh;
    axil_data_t buffl;
    blk_count_t buff_size;

    // Response channel state
    logic       b_valid;
    axi_resp_t  b_resp;
    logic       r_valid;
    axi_resp_t  r_resp;
    axil_data_t r_data;

    // ========================================
    // Address decode
    // ========================================

    // Byte address bits 6 to 2 select the word
    reg_idx_t   wr_idx;
    reg_idx_t   rd_idx;
    logic       wr_ok;
    logic       rd_ok;
    axil_data_t rd_word;

    assign wr_idx = s_wreq.aw_addr[6:2];
    assign rd_idx = s_rreq.addr[6:2];

    // Start is write-only so it decodes for writes alone
    assign wr_ok = (wr_idx <= reg_start);
    assign rd_ok = (rd_idx <= reg_buff_size);

    always_comb begin
        rd_word = '0;
        case (rd_idx)
            reg_buffh:     rd_word = buffh;
            reg_buffl:     rd_word = buffl;
            reg_buff_size: rd_word = buff_size;
            default:       rd_word = '0;
        endcase
    end

    // ========================================
    // Handshakes
    // ========================================

    // AW and W are taken together and only once B has been consumed
    logic wr_accept;
    logic rd_accept;

    assign wr_accept  = s_wreq.aw_valid && s_wreq.w_valid && !b_valid;
    assign s_aw_ready = wr_accept;
    assign s_w_ready  = wr_accept;

    // One read in flight at a time
    assign s_ar_ready = !r_valid;
    assign rd_accept  = s_rreq.valid && !r_valid;

    // ========================================
    // Control state
    // ========================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            buffh     <= buffh_reset;
            buffl     <= buffl_reset;
            buff_size <= size_reset;
            b_valid   <= 1'b0;
            r_valid   <= 1'b0;
            start     <= 1'b0;
        end else begin
            // Start lasts a single cycle
            start <= 1'b0;

            if (wr_accept) begin
                b_valid <= 1'b1;
                case (wr_idx)
                    reg_buffh:     buffh     <= s_wreq.w_data;
                    reg_buffl:     buffl     <= s_wreq.w_data;
                    reg_buff_size: buff_size <= s_wreq.w_data;
                    reg_start:     start     <= 1'b1;
                    default:       start     <= 1'b0;
                endcase
            end else if (s_b_ready) begin
                b_valid <= 1'b0;
            end

            if (rd_accept) begin
                r_valid <= 1'b1;
            end else if (s_r_ready) begin
                r_valid <= 1'b0;
            end
        end
    end

    // Response payloads are captured at acceptance
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            b_resp <= wr_ok ? resp_okay : resp_decerr;
        end
        if (rd_accept) begin
            r_data <= rd_word;
            r_resp <= rd_ok ? resp_okay : resp_decerr;
        end
    end

    // ========================================
    // Outputs
    // ========================================
    assign s_wrsp = '{resp: b_resp, valid: b_valid};
    assign s_rrsp = '{data: r_data, resp: r_resp, valid: r_valid};
    assign cfg    = '{base: {buffh, buffl}, size: buff_size};

    // A response waits until the host takes it
    a_b_hold: assert property (@(posedge clk) disable iff (!resetn)
        s_wrsp.valid && !s_b_ready |=> s_wrsp.valid && $stable(s_wrsp.resp));

    a_r_hold: assert property (@(posedge clk) disable iff (!resetn)
        s_rrsp.valid && !s_r_ready |=> s_rrsp.valid && $stable(s_rrsp.data));

endmodule

/* common/ecd_ctrl_pkg.sv */
// ========================================
// Register map and buffer configuration
// ========================================
package ecd_ctrl_pkg;

    // Word index into the 128-byte register window
    typedef logic [4:0] reg_idx_t;

    // Register map
    // Buffer base address high word
    localparam reg_idx_t reg_buffh     = 5'd0;
    // Buffer base address low word
    localparam reg_idx_t reg_buffl     = 5'd1;
    // Buffer size in bursts
    localparam reg_idx_t reg_buff_size = 5'd2;
    // Any write here starts the DMA
    localparam reg_idx_t reg_start     = 5'd3;

    // Response codes returned on B and R
    localparam ecd_axi_pkg::axi_resp_t resp_okay   = 2'b00;
    localparam ecd_axi_pkg::axi_resp_t resp_decerr = 2'b11;

    // Count of blocks in one buffer
    typedef logic [31:0] blk_count_t;

    // Register contents after reset
    localparam ecd_axi_pkg::axil_data_t buffl_reset = 32'hC000_0000;
    localparam ecd_axi_pkg::axil_data_t buffh_reset = 32'h0000_0000;
    localparam blk_count_t              size_reset  = 32'd8;

    // Buffer description handed to the fetch logic
    typedef struct packed {
        ecd_axi_pkg::axi_addr_t base;
        blk_count_t             size;
    } buf_cfg_t;

endpackage

/* common/ecd_axi_pkg.sv */
// ========================================
// Bus widths and channel bundles
// ========================================
package ecd_axi_pkg;

    // Master data path is fixed at 64 bytes per beat
    localparam int axi_data_w     = 512;
    localparam int axi_addr_w     = 64;
    localparam int axi_data_bytes = axi_data_w / 8;

    // Register port vectors
    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;

    // Master port vectors
    typedef logic [axi_addr_w-1:0] axi_addr_t;
    typedef logic [axi_data_w-1:0] axi_data_t;
    typedef logic [7:0]            axi_len_t;
    typedef logic [2:0]            axi_size_t;
    typedef logic [1:0]            axi_burst_t;
    typedef logic [1:0]            axi_resp_t;

    // Burst type encoding for incrementing bursts
    localparam axi_burst_t burst_incr = 2'b01;

    // AXI4-Lite write request with AW and W travelling together
    typedef struct packed {
        axil_addr_t aw_addr;
        logic       aw_valid;
        axil_data_t w_data;
        logic       w_valid;
    } axil_wreq_t;

    // AXI4-Lite read request
    typedef struct packed {
        axil_addr_t addr;
        logic       valid;
    } axil_rreq_t;

    // AXI4-Lite write response
    typedef struct packed {
        axi_resp_t resp;
        logic      valid;
    } axil_wrsp_t;

    // AXI4-Lite read response
    typedef struct packed {
        axil_data_t data;
        axi_resp_t  resp;
        logic       valid;
    } axil_rrsp_t;

    // AXI4 read address channel
    typedef struct packed {
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        logic       valid;
    } axi_ar_t;

    // AXI4 read data channel
    typedef struct packed {
        axi_data_t data;
        logic      last;
        logic      valid;
    } axi_r_t;

    // AXI-Stream beat
    typedef struct packed {
        axi_data_t data;
        logic      valid;
    } axis_t;

endpackage
